// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_bbox_iterator
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
HEADERS := testbench/tb_cases.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Checks failed" $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/bbox_iterator.sv
`timescale 1ns/100ps
`default_nettype none

// Bounding box sample iterator
// One sample per cycle, triangle and colour travel with each sample
module bbox_iterator #(
    // Fraction bits of the fixed-point coordinates
    parameter int RADIX = raster_pkg::RADIX_DEFAULT
) (
    input  wire logic                clk,
    input  wire logic                rst,
    // APB configuration port
    input  wire logic [3:0]          paddr,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire logic [31:0]         pwdata,
    output logic      [31:0]         prdata,
    output logic                     pready,
    output logic                     pslverr,
    // Triangle input
    input  wire logic                valid_tri,
    input  wire raster_pkg::tri_t    tri_in,
    input  wire raster_pkg::color_t  color_in,
    input  wire raster_pkg::box_t    box_in,
    output logic                     ready,
    // Sample output
    output raster_pkg::tri_t         tri_out,
    output raster_pkg::color_t       color_out,
    output raster_pkg::point_t       sample,
    output logic                     valid_samp
);

    import raster_pkg::*;

    // Step derived from the multisample mode
    coord_t sample_step;
    // Controller to stepper
    logic   load;
    logic   advance;
    // Stepper to controller
    logic   at_end;

    raster_config #(
        .RADIX (RADIX)
    ) u_config (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .sample_step (sample_step)
    );

    // Position datapath
    sample_stepper u_stepper (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .advance     (advance),
        .box_in      (box_in),
        .sample_step (sample_step),
        .sample      (sample),
        .at_end      (at_end)
    );

    // Handshake and held triangle
    iter_control u_control (
        .clk        (clk),
        .rst        (rst),
        .valid_tri  (valid_tri),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .at_end     (at_end),
        .load       (load),
        .advance    (advance),
        .ready      (ready),
        .valid_samp (valid_samp),
        .tri_out    (tri_out),
        .color_out  (color_out)
    );

endmodule

`default_nettype wire

// File: hdl/iter_control.sv
`timescale 1ns/100ps
`default_nettype none

// Wait/test FSM for the bounding box walk
// Holds upstream while a box is being walked
module iter_control (
    input  wire logic                clk,
    input  wire logic                rst,
    // Upstream triangle handshake and payload
    input  wire logic                valid_tri,
    input  wire raster_pkg::tri_t    tri_in,
    input  wire raster_pkg::color_t  color_in,
    // Last sample of the box is on the output
    input  wire logic                at_end,
    // Stepper commands
    output logic                     load,
    output logic                     advance,
    output logic                     ready,
    output logic                     valid_samp,
    output raster_pkg::tri_t         tri_out,
    output raster_pkg::color_t       color_out
);

    import raster_pkg::*;

    typedef enum logic {
        WAIT_ST,
        TEST_ST
    } state_t;

    state_t state;
    state_t state_next;
    logic   ready_next;
    logic   valid_next;

    // Ready is high exactly in the wait state
    assign load = ready && valid_tri;

    // Keep stepping until the last sample has gone out
    assign advance = (state == TEST_ST) && !at_end;

    always_comb begin
        state_next = state;
        ready_next = ready;
        valid_next = valid_samp;
        case (state)
            WAIT_ST: begin
                // First sample appears the cycle after acceptance
                if (load) begin
                    state_next = TEST_ST;
                    ready_next = 1'b0;
                    valid_next = 1'b1;
                end
            end
            TEST_ST: begin
                // Release upstream right after the final sample
                if (at_end) begin
                    state_next = WAIT_ST;
                    ready_next = 1'b1;
                    valid_next = 1'b0;
                end
            end
            default: begin
                state_next = WAIT_ST;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= WAIT_ST;
            ready      <= 1'b1;
            valid_samp <= 1'b0;
        end else begin
            state      <= state_next;
            ready      <= ready_next;
            valid_samp <= valid_next;
        end
    end

    // Triangle and colour stay put until the next acceptance
    always_ff @(posedge clk) begin
        if (load) begin
            tri_out   <= tri_in;
            color_out <= color_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_config.sv
`timescale 1ns/100ps
`default_nettype none

// APB register block holding the multisample mode
// Mode register at address 0, no other registers
module raster_config #(
    parameter int RADIX = raster_pkg::RADIX_DEFAULT
) (
    input  wire logic             clk,
    input  wire logic             rst,
    // APB slave side
    input  wire logic [3:0]       paddr,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire logic [31:0]      pwdata,
    output logic      [31:0]      prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Spacing between neighbouring samples
    output raster_pkg::coord_t    sample_step
);

    import raster_pkg::*;

    localparam logic [3:0] MODE_ADDR = 4'h0;

    // Current mode
    msaa_mode_t mode;
    // Decode of the current transfer
    logic       access;
    logic       addr_ok;
    logic       wdata_ok;
    logic       wr_en;

    // Access phase of a transfer, setup phase does nothing here
    assign access = psel && penable;

    assign addr_ok = (paddr == MODE_ADDR);

    // Exactly one bit set in the low nibble and nothing above it
    always_comb begin
        case (pwdata[3:0])
            4'b1000, 4'b0100, 4'b0010, 4'b0001: begin
                wdata_ok = (pwdata[31:4] == 28'd0);
            end
            default: begin
                wdata_ok = 1'b0;
            end
        endcase
    end

    // Refused writes leave the register untouched
    assign wr_en = access && pwrite && addr_ok && wdata_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= MSAA_RESET;
        end else if (wr_en) begin
            mode <= msaa_mode_t'(pwdata[3:0]);
        end
    end

    // No wait states
    assign pready = 1'b1;

    // Error on a bad address, or on a write that is not one-hot
    assign pslverr = access && (!addr_ok || (pwrite && !wdata_ok));

    // Mode in the low nibble, zero for unmapped addresses
    assign prdata = addr_ok ? {28'd0, mode} : 32'd0;

    // 1x gives one pixel, each finer mode halves the step
    // Bit 3 of the mode lands on the radix point
    assign sample_step = coord_t'(mode) << (RADIX - 3);

endmodule

`default_nettype wire

// File: hdl/raster_pkg.sv
`default_nettype none

package raster_pkg;

    // Bits in a coordinate or a colour channel
    localparam int SIG_FIG = 24;
    // Fraction bits of a fixed-point coordinate
    localparam int RADIX_DEFAULT = 10;
    // Triangle shape
    localparam int VERTS = 3;
    localparam int AXES = 3;
    localparam int COLORS = 3;

    // Signed fixed point, integer part above the radix point
    typedef logic signed [SIG_FIG-1:0] coord_t;

    // Sample or corner position, x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Bounding box, lower-left corner in the upper half
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef vertex_t [VERTS-1:0] tri_t;

    // Unsigned colour channels
    typedef logic [COLORS-1:0][SIG_FIG-1:0] color_t;

    // One-hot multisample mode
    // 1000 = 1x, 0100 = 4x, 0010 = 16x, 0001 = 64x
    typedef logic [3:0] msaa_mode_t;
    localparam msaa_mode_t MSAA_RESET = 4'b1000;

endpackage

`default_nettype wire

// File: hdl/sample_stepper.sv
`timescale 1ns/100ps
`default_nettype none

// Walks sample positions across a bounding box
// Raster order: left to right, then one row up
module sample_stepper (
    input  wire logic                clk,
    input  wire logic                rst,
    // Start a new box at its lower-left corner
    input  wire logic                load,
    // Move on to the next sample
    input  wire logic                advance,
    input  wire raster_pkg::box_t    box_in,
    input  wire raster_pkg::coord_t  sample_step,
    output raster_pkg::point_t       sample,
    // Current sample is the last one of the box
    output logic                     at_end
);

    import raster_pkg::*;

    // Box being walked
    box_t   box_q;
    // Current sample position
    point_t sample_q;
    // Candidate positions for the next cycle
    point_t step_right;
    point_t step_up;
    point_t sample_next;
    // Edge flags for the current sample
    logic   at_right;
    logic   at_top;

    // Box is captured once per triangle
    always_ff @(posedge clk) begin
        if (load) begin
            box_q <= box_in;
        end
    end

    // Edges are reached at or past the upper-right corner
    // Signed compare, coordinates may be negative
    assign at_right = (sample_q.x >= box_q.ur.x);
    assign at_top   = (sample_q.y >= box_q.ur.y);
    assign at_end   = at_right && at_top;

    // One step to the right on the same row
    always_comb begin
        step_right.x = sample_q.x + sample_step;
        step_right.y = sample_q.y;
    end

    // Back to the left edge, one row up
    always_comb begin
        step_up.x = box_q.ll.x;
        step_up.y = sample_q.y + sample_step;
    end

    // Wrap once the right edge is reached
    assign sample_next = at_right ? step_up : step_right;

    // Load wins over advance, otherwise hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_q <= '0;
        end else if (load) begin
            sample_q <= box_in.ll;
        end else if (advance) begin
            sample_q <= sample_next;
        end
    end

    assign sample = sample_q;

endmodule

`default_nettype wire

// File: sim.f
+incdir+testbench
hdl/raster_pkg.sv
hdl/raster_config.sv
hdl/sample_stepper.sv
hdl/iter_control.sv
hdl/bbox_iterator.sv
testbench/tb_bbox_iterator.sv

// File: testbench/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// Stimulus table, one row per triangle
// Columns: index, mode, ll.x, ll.y, ur.x, ur.y, columns, rows, back-to-back
// Coordinates in fixed point, 1024 is one pixel
localparam int NUM_CASES = 8;

msaa_mode_t case_mode  [NUM_CASES];
box_t       case_box   [NUM_CASES];
int         case_cols  [NUM_CASES];
int         case_rows  [NUM_CASES];
// Presented straight after the previous triangle, mode unchanged
bit         case_b2b   [NUM_CASES];
// Payload, filled from the LFSR at start of run
tri_t       case_tri   [NUM_CASES];
color_t     case_color [NUM_CASES];

task automatic set_case(input int idx, input msaa_mode_t mode, input int llx, input int lly,
                        input int urx, input int ury, input int cols, input int rows,
                        input bit b2b);
    case_mode[idx]   = mode;
    case_box[idx].ll.x = coord_t'(llx);
    case_box[idx].ll.y = coord_t'(lly);
    case_box[idx].ur.x = coord_t'(urx);
    case_box[idx].ur.y = coord_t'(ury);
    case_cols[idx]   = cols;
    case_rows[idx]   = rows;
    case_b2b[idx]    = b2b;
endtask

task automatic load_table();
    set_case(0, 4'b1000,     0,     0,  3072,  2048, 4, 3, 1'b0);
    set_case(1, 4'b1000, -2048, -1024,    -1,     0, 3, 2, 1'b1);
    set_case(2, 4'b0100,  1024,  2048,  2048,  3072, 3, 3, 1'b0);
    set_case(3, 4'b0100,     0,     0,   700,     0, 3, 1, 1'b1);
    set_case(4, 4'b0010,  -512,  -256,   300,   200, 5, 3, 1'b0);
    set_case(5, 4'b0001,   100,    50,   500,   200, 5, 3, 1'b0);
    // Single sample box
    set_case(6, 4'b1000,  5120,  5120,  5120,  5120, 1, 1, 1'b0);
    set_case(7, 4'b1000,     0,  1024,  1024,  1024, 2, 1, 1'b1);
endtask

`endif

// File: testbench/tb_bbox_iterator.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bbox_iterator;

    import raster_pkg::*;

    localparam int RADIX = RADIX_DEFAULT;
    // Cycle bound for every wait loop
    localparam int WAIT_LIMIT = 64;
    // No box in the table comes close to this
    localparam int SAMPLE_LIMIT = 512;

    logic        clk;
    logic        rst;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        valid_tri;
    tri_t        tri_in;
    color_t      color_in;
    box_t        box_in;
    logic        ready;
    tri_t        tri_out;
    color_t      color_out;
    point_t      sample;
    logic        valid_samp;

    logic [31:0] lfsr_state;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          test_start_errors;
    string       test_name;
    bit          timed_out;
    int          idx;

    `include "tb_cases.svh"

    bbox_iterator #(
        .RADIX (RADIX)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .valid_tri  (valid_tri),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .box_in     (box_in),
        .ready      (ready),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .sample     (sample),
        .valid_samp (valid_samp)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [SIG_FIG-1:0] lfsr_word();
        logic [SIG_FIG-1:0] word;
        logic               fb;
        int                 b;
        word = '0;
        for (b = 0; b < SIG_FIG; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            word = {word[SIG_FIG-2:0], fb};
        end
        return word;
    endfunction

    function automatic tri_t random_tri();
        tri_t t;
        int   v;
        for (v = 0; v < VERTS; v++) begin
            t[v].x = lfsr_word();
            t[v].y = lfsr_word();
            t[v].z = lfsr_word();
        end
        return t;
    endfunction

    function automatic color_t random_color();
        color_t col;
        int     c;
        for (c = 0; c < COLORS; c++) begin
            col[c] = lfsr_word();
        end
        return col;
    endfunction

    // Junk box for upstream while held off
    function automatic box_t random_box();
        box_t bx;
        bx.ll.x = lfsr_word();
        bx.ll.y = lfsr_word();
        bx.ur.x = lfsr_word();
        bx.ur.y = lfsr_word();
        return bx;
    endfunction

    // One pixel at 1x, halved for each finer mode
    function automatic coord_t step_for_mode(input msaa_mode_t mode);
        case (mode)
            4'b1000: return coord_t'(1 << RADIX);
            4'b0100: return coord_t'(1 << (RADIX - 1));
            4'b0010: return coord_t'(1 << (RADIX - 2));
            default: return coord_t'(1 << (RADIX - 3));
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] exp_v,
                                   input logic [255:0] act_v);
        error_count++;
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start_errors = error_count;
        test_count++;
    endtask

    task automatic end_test();
        if (error_count == test_start_errors) begin
            $display("%s: ok", test_name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", test_name, error_count - test_start_errors);
        end
    endtask

    // Setup cycle, then access cycle held until pready
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (pready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pready !== 1'b1) begin
            timed_out = 1'b1;
            error_count++;
            $display("APB access to address %0h got no pready in %0d cycles", addr, WAIT_LIMIT);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        if (err !== exp_err)
            report_mismatch("pslverr", 256'(exp_err), 256'(err));
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
                               input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        if (err !== exp_err)
            report_mismatch("pslverr", 256'(exp_err), 256'(err));
        if (!exp_err && rdata !== exp_data)
            report_mismatch("prdata", 256'(exp_data), 256'(rdata));
    endtask

    task automatic drive_triangle(input int i);
        valid_tri <= 1'b1;
        tri_in    <= case_tri[i];
        color_in  <= case_color[i];
        box_in    <= case_box[i];
    endtask

    // Upstream keeps changing while held off
    task automatic drive_filler(input bit hold_valid);
        valid_tri <= hold_valid;
        tri_in    <= random_tri();
        color_in  <= random_color();
        box_in    <= random_box();
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (ready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ready !== 1'b1) begin
            timed_out = 1'b1;
            error_count++;
            $display("ready did not return high within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic run_case(input int i);
        coord_t ll_x;
        coord_t ur_x;
        coord_t exp_x;
        coord_t exp_y;
        coord_t step;
        point_t exp_pt;
        int     count;
        int     total;
        bit     next_b2b;
        ll_x  = case_box[i].ll.x;
        ur_x  = case_box[i].ur.x;
        exp_x = ll_x;
        exp_y = case_box[i].ll.y;
        step  = step_for_mode(case_mode[i]);
        total = case_cols[i] * case_rows[i];
        count = 0;
        if (i + 1 < NUM_CASES)
            next_b2b = case_b2b[i + 1];
        else
            next_b2b = 1'b0;
        // Back-to-back rows were already driven on the previous last sample
        if (!case_b2b[i]) begin
            wait_ready();
            if (timed_out)
                return;
            write_expect(4'h0, {28'd0, case_mode[i]}, 1'b0);
            @(posedge clk);
            drive_triangle(i);
            @(negedge clk);
        end
        if (ready !== 1'b1)
            report_mismatch("ready", 256'd1, 256'(ready));
        // Acceptance edge
        @(posedge clk);
        drive_filler(next_b2b);
        while (count <= SAMPLE_LIMIT) begin
            @(negedge clk);
            if (!valid_samp)
                break;
            count++;
            exp_pt.x = exp_x;
            exp_pt.y = exp_y;
            if (sample !== exp_pt)
                report_mismatch("sample", 256'(exp_pt), 256'(sample));
            if (tri_out !== case_tri[i])
                report_mismatch("tri_out", 256'(case_tri[i]), 256'(tri_out));
            if (color_out !== case_color[i])
                report_mismatch("color_out", 256'(case_color[i]), 256'(color_out));
            if (ready !== 1'b0)
                report_mismatch("ready", 256'd0, 256'(ready));
            // Back to the left edge one row up once the right edge is reached
            if (exp_x >= ur_x) begin
                exp_x = ll_x;
                exp_y = exp_y + step;
            end else begin
                exp_x = exp_x + step;
            end
            @(posedge clk);
            if (next_b2b && count == total)
                drive_triangle(i + 1);
            else
                drive_filler(next_b2b);
        end
        if (count > SAMPLE_LIMIT) begin
            timed_out = 1'b1;
            error_count++;
            $display("valid_samp stayed high for more than %0d samples", SAMPLE_LIMIT);
        end else if (count == 0) begin
            error_count++;
            $display("valid_samp did not rise one cycle after acceptance, at %0t", $time);
        end else begin
            if (count != total)
                report_mismatch("sample count", 256'(total), 256'(count));
            if (ready !== 1'b1)
                report_mismatch("ready", 256'd1, 256'(ready));
        end
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk       = 1'b0;
        rst       = 1'b1;
        paddr     = 4'h0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = 32'd0;
        valid_tri = 1'b0;
        tri_in    = '0;
        color_in  = '0;
        box_in    = '0;
        lfsr_state   = 32'hd5e4;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        load_table();
        for (idx = 0; idx < NUM_CASES; idx++) begin
            case_tri[idx]   = random_tri();
            case_color[idx] = random_color();
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        @(negedge clk);
        if (ready !== 1'b1)
            report_mismatch("ready", 256'd1, 256'(ready));
        if (valid_samp !== 1'b0)
            report_mismatch("valid_samp", 256'd0, 256'(valid_samp));
        read_expect(4'h0, 32'h8, 1'b0);
        end_test();

        begin_test("config");
        write_expect(4'h0, 32'h4, 1'b0);
        read_expect(4'h0, 32'h4, 1'b0);
        // Two bits set, a one-hot nibble with a high bit, and no bit at all
        write_expect(4'h0, 32'h6, 1'b1);
        write_expect(4'h0, 32'h14, 1'b1);
        write_expect(4'h0, 32'h0, 1'b1);
        // Unmapped addresses
        write_expect(4'h5, 32'h1, 1'b1);
        read_expect(4'h3, 32'h0, 1'b1);
        read_expect(4'h0, 32'h4, 1'b0);
        end_test();

        for (idx = 0; idx < NUM_CASES && !timed_out; idx++) begin
            begin_test($sformatf("case %0d", idx));
            run_case(idx);
            end_test();
        end

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0 && !timed_out)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
